/* project.f */
+incdir+include
+incdir+verif
src/adc_rx_pkg.sv
src/lane_word_if.sv
src/lane_deserializer.sv
src/frame_aligner.sv
src/sample_assembler.sv
src/adc_config_sequencer.sv
src/spi_master.sv
src/ltc2195_rx_top.sv
verif/tb_ltc2195_rx.sv

/* Bender.yml */
package:
  name: ltc2195_rx

export_include_dirs:
  - include

sources:
  - files:
      - src/adc_rx_pkg.sv
      - src/lane_word_if.sv
      - src/lane_deserializer.sv
      - src/frame_aligner.sv
      - src/sample_assembler.sv
      - src/adc_config_sequencer.sv
      - src/spi_master.sv
      - src/ltc2195_rx_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_ltc2195_rx.sv

/* verif/tb_ltc2195_tasks.svh */
`ifndef TB_LTC2195_TASKS_SVH
`define TB_LTC2195_TASKS_SVH

//////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////
function automatic logic [31:0] xorshift();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// Mid cycle, after the monitors have run
task automatic next_cycle();
	@(negedge hz_clk);
	#1;
endtask

task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
	assert (act === exp) else begin
		$display("** Error: %s expected %h actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic report_test(input string name);
	$display("Test %s: %s, %0d errors", name, (errors == 0) ? "ok" : "failed", errors);
	if (errors != 0)
		tests_failed++;
	total_errors = total_errors + errors;
	errors = 0;
endtask

task automatic send_cmd(input logic [15:0] addr, input logic [15:0] data);
	@(posedge hz_clk);
	#10;
	cmd_trig = 1'b1;
	cmd_addr = addr;
	cmd_data = data;
	@(posedge hz_clk);
	#10;
	cmd_trig = 1'b0; // One cycle pulse
endtask

task automatic wait_lock(input string name);
	int n;
	n = 0;
	while (!frame_locked && n < LOCK_CYC) begin
		next_cycle();
		n++;
	end
	assert (frame_locked) else begin
		$display("%s: frame_locked did not rise within %0d cycles", name, LOCK_CYC);
		errors++;
	end
endtask

// Up to two filler words may come out before the queued pairs
task automatic compare_samples(input string name);
	int n;
	int skip;
	n = 0;
	while (got_q.size() < exp_q.size() + 2 && n < (exp_q.size() + 4) * 9) begin
		next_cycle();
		n++;
	end
	skip = 0;
	while (got_q.size() > 0 && got_q[0] == 32'h0 && skip < 2) begin
		void'(got_q.pop_front());
		skip++;
	end
	assert (got_q.size() >= exp_q.size()) else begin
		$display("%s: only %0d of %0d samples arrived", name, got_q.size(), exp_q.size());
		errors++;
	end
	for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
		expect_equal($sformatf("%s sample %0d", name, i), exp_q[i], got_q[i]);
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////
task automatic powerup_config();
	logic [15:0] exp_f [3];
	int n;
	exp_f[0] = 16'h0080; // Software reset
	exp_f[1] = 16'h0120; // Two's complement
	exp_f[2] = 16'h0200; // Two lanes
	n = 0;
	while (!cfg_done && n < `CFG_POWERUP_WAIT + 4 * XFER_CYC) begin
		next_cycle();
		n++;
	end
	assert (cfg_done) else begin
		$display("powerup_config: cfg_done never rose");
		errors++;
	end
	expect_equal("powerup_config count", 32'd3, spi_q.size());
	for (int i = 0; i < 3 && i < spi_q.size(); i++)
		expect_equal($sformatf("powerup_config frame %0d", i), exp_f[i], spi_q[i]);
	spi_q.delete();
	report_test("powerup_config");
endtask

task automatic user_write();
	int n;
	bit cs_seen;
	send_cmd(16'h3105, 16'h00AB);
	n = 0;
	while (spi_q.size() == 0 && n < 2 * XFER_CYC) begin
		next_cycle();
		n++;
	end
	expect_equal("user_write count", 32'd1, spi_q.size());
	if (spi_q.size() > 0)
		expect_equal("user_write frame", 16'h05AB, spi_q.pop_front()); // Address 5, data AB
	while (!spi_cs_n)
		next_cycle();
	send_cmd(16'h3005, 16'h00CD); // Wrong prefix, must be dropped
	cs_seen = 1'b0;
	repeat (XFER_CYC + 8) begin
		next_cycle();
		if (!spi_cs_n)
			cs_seen = 1'b1;
	end
	expect_equal("user_write ignored cs_n", 32'd0, cs_seen);
	expect_equal("user_write cfg_done", 32'd1, cfg_done);
	spi_q.delete();
	report_test("user_write");
endtask

task automatic frame_lock();
	int offset;
	offset = int'(xorshift() % 8);
	next_cycle();
	assert (!frame_locked) else begin
		$display("frame_lock: frame_locked high while the lanes are idle");
		errors++;
	end
	ins_bits = offset; // Random start inside the word
	tx_en    = 1'b1;
	wait_lock("frame_lock");
	report_test("frame_lock");
endtask

task automatic sample_reconstruction();
	logic [31:0] pair;
	next_cycle();
	got_q.delete();
	exp_q.delete();
	for (int i = 0; i < 64; i++) begin
		pair = xorshift();
		exp_q.push_back(pair);
		tx_q.push_back(pair);
	end
	compare_samples("sample_reconstruction");
	report_test("sample_reconstruction");
endtask

task automatic realignment();
	logic [31:0] pair;
	int n;
	next_cycle();
	ins_bits = 1; // One extra bit on every lane
	n = 0;
	while (frame_locked && n < 3 * 9) begin
		next_cycle();
		n++;
	end
	assert (!frame_locked) else begin
		$display("realignment: frame_locked stayed high after the extra bit");
		errors++;
	end
	wait_lock("realignment");
	got_q.delete();
	exp_q.delete();
	for (int i = 0; i < 16; i++) begin
		pair = xorshift();
		exp_q.push_back(pair);
		tx_q.push_back(pair);
	end
	compare_samples("realignment");
	report_test("realignment");
endtask

`endif

/* verif/tb_ltc2195_rx.sv */
`include "adc_rx_defines.svh"

module tb_ltc2195_rx import adc_rx_pkg::*; ();

	localparam int XFER_CYC  = `SPI_FRAME_W * 2 * `SPI_CLK_DIV + 2; // One SPI write
	localparam int LOCK_CYC  = (8 * 4 + 2) * 9; // Lock bound, every word counted as 9 bits
	localparam int LIMIT_CYC = `CFG_POWERUP_WAIT + 6 * XFER_CYC + 300 * 9 + 1000;
	localparam logic [3:0] INV_MASK = `ADC_LANE_INVERT;

	logic        hz_clk;
	logic        rst_in;
	logic        frame_lane;
	logic [3:0]  data_lanes;
	logic        cmd_trig;
	logic [15:0] cmd_addr;
	logic [15:0] cmd_data;
	logic        spi_cs_n;
	logic        spi_sck;
	logic        spi_sdo;
	logic        cfg_done;
	logic        frame_locked;
	sample_t     sample_ch0;
	sample_t     sample_ch1;
	logic        sample_valid;

	int          errors;        // Errors of the running test
	int          total_errors;
	int          tests_failed;
	int          cycle_cnt;
	logic [31:0] rng_state;

	// ADC lane model, pairs are {ch0, ch1}
	logic [31:0] tx_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] got_q[$];      // Pairs seen on the sample outputs
	logic [15:0] spi_q[$];      // Frames seen on the SPI pins
	bit          tx_en;
	int          ins_bits;      // Idle bits put in before the next word
	int          tx_bit;
	logic [7:0]  tx_frame;
	logic [7:0]  tx_data [4];   // ch0a, ch0b, ch1a, ch1b
	logic [15:0] spi_sh;
	int          spi_bits;
	logic        sck_q;

	ltc2195_rx_top u_ltc2195_rx_top (
		.hz_clk(hz_clk), .rst_in(rst_in),
		.frame_lane(frame_lane), .data_lanes(data_lanes),
		.cmd_trig(cmd_trig), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.spi_cs_n(spi_cs_n), .spi_sck(spi_sck), .spi_sdo(spi_sdo),
		.cfg_done(cfg_done), .frame_locked(frame_locked),
		.sample_ch0(sample_ch0), .sample_ch1(sample_ch1), .sample_valid(sample_valid)
	);

	initial hz_clk = 1'b0;
	always #50 hz_clk = ~hz_clk;

	//////////////////////////////////////////////////
	// ADC model, MSB first, one bit per cycle
	//////////////////////////////////////////////////
	// Lane a carries the odd sample bits, lane b the even ones
	function automatic logic [15:0] split_sample(input logic [15:0] s);
		logic [7:0] a;
		logic [7:0] b;
		for (int k = 0; k < 8; k++) begin
			a[k] = s[2*k+1];
			b[k] = s[2*k];
		end
		return {a, b};
	endfunction

	task automatic load_word();
		logic [31:0] pair;
		pair = 32'h0; // Filler while the queue is empty
		if (tx_q.size() > 0)
			pair = tx_q.pop_front();
		{tx_data[0], tx_data[1]} = split_sample(pair[31:16]);
		{tx_data[2], tx_data[3]} = split_sample(pair[15:0]);
		for (int i = 0; i < 4; i++) begin
			if (INV_MASK[i])
				tx_data[i] = ~tx_data[i]; // Swapped board pair
		end
		tx_frame = `ADC_FRAME_PATTERN;
	endtask

	always @(posedge hz_clk) begin
		#10;
		if (!tx_en || (ins_bits > 0 && tx_bit == 0)) begin
			if (tx_en)
				ins_bits = ins_bits - 1; // Extra bit between words
			frame_lane = 1'b0;
			data_lanes = '0;
		end else begin
			if (tx_bit == 0)
				load_word();
			frame_lane = tx_frame[7 - tx_bit];
			for (int i = 0; i < 4; i++)
				data_lanes[i] = tx_data[i][7 - tx_bit];
			tx_bit = (tx_bit + 1) % 8;
		end
	end

	//////////////////////////////////////////////////
	// SPI and sample monitors, mid cycle
	//////////////////////////////////////////////////
	always @(negedge hz_clk) begin
		if (spi_cs_n) begin
			spi_bits = 0;
		end else if (spi_sck && !sck_q) begin // Rising sck
			spi_sh   = {spi_sh[14:0], spi_sdo};
			spi_bits = spi_bits + 1;
			if (spi_bits == 16)
				spi_q.push_back(spi_sh);
		end
		sck_q = spi_sck;
		if (sample_valid)
			got_q.push_back({sample_ch0, sample_ch1});
	end

	// Run limit
	always @(posedge hz_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= LIMIT_CYC) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	`include "tb_ltc2195_tasks.svh"

	initial begin
		rst_in       = 1'b1;
		frame_lane   = 1'b0;
		data_lanes   = '0;
		cmd_trig     = 1'b0;
		cmd_addr     = '0;
		cmd_data     = '0;
		errors       = 0;
		total_errors = 0;
		tests_failed = 0;
		cycle_cnt    = 0;
		rng_state    = 32'd49804;
		tx_en        = 1'b0;
		ins_bits     = 0;
		tx_bit       = 0;
		tx_frame     = '0;
		spi_sh       = '0;
		spi_bits     = 0;
		sck_q        = 1'b0;
		repeat (5) @(posedge hz_clk);
		#10 rst_in = 1'b0;
		powerup_config();
		user_write();
		frame_lock();
		sample_reconstruction();
		realignment();
		$display("Summary: 5 tests, %0d failed, %0d errors", tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* src/ltc2195_rx_top.sv */
module ltc2195_rx_top import adc_rx_pkg::*; (
	input  logic        hz_clk,
	input  logic        rst_in,
	// Serial lanes from the ADC
	input  logic        frame_lane,
	input  logic [3:0]  data_lanes,  // ch0a, ch0b, ch1a, ch1b
	// Register write commands
	input  logic        cmd_trig,
	input  logic [15:0] cmd_addr,
	input  logic [15:0] cmd_data,
	// SPI to the ADC
	output logic        spi_cs_n,
	output logic        spi_sck,
	output logic        spi_sdo,
	// Status
	output logic        cfg_done,
	output logic        frame_locked,
	// Sample outputs
	output sample_t     sample_ch0,
	output sample_t     sample_ch1,
	output logic        sample_valid
);

	logic        spi_start;
	logic [15:0] spi_frame;
	logic        spi_ready;

	lane_word_if u_words ();

	//////////////////////////////////////////////////
	// Receive chain
	//////////////////////////////////////////////////
	lane_deserializer u_lane_deserializer (
		.hz_clk(hz_clk), .rst_in(rst_in),
		.frame_lane(frame_lane), .data_lanes(data_lanes),
		.words(u_words.deserializer)
	);

	frame_aligner u_frame_aligner (
		.hz_clk(hz_clk), .rst_in(rst_in),
		.words(u_words.aligner), .frame_locked(frame_locked)
	);

	sample_assembler u_sample_assembler (
		.hz_clk(hz_clk), .rst_in(rst_in),
		.words(u_words.assembler), .frame_locked(frame_locked),
		.sample_ch0(sample_ch0), .sample_ch1(sample_ch1), .sample_valid(sample_valid)
	);

	//////////////////////////////////////////////////
	// Configuration chain
	//////////////////////////////////////////////////
	adc_config_sequencer u_adc_config_sequencer (
		.hz_clk(hz_clk), .rst_in(rst_in),
		.cmd_trig(cmd_trig), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.spi_ready(spi_ready), .spi_start(spi_start), .spi_frame(spi_frame),
		.cfg_done(cfg_done)
	);

	spi_master u_spi_master (
		.hz_clk(hz_clk), .rst_in(rst_in),
		.spi_start(spi_start), .spi_frame(spi_frame), .spi_ready(spi_ready),
		.spi_cs_n(spi_cs_n), .spi_sck(spi_sck), .spi_sdo(spi_sdo)
	);

endmodule

/* src/spi_master.sv */
`include "adc_rx_defines.svh"

module spi_master import adc_rx_pkg::*; (
	input  logic                    hz_clk,
	input  logic                    rst_in,
	input  logic                    spi_start,
	input  logic [`SPI_FRAME_W-1:0] spi_frame,
	output logic                    spi_ready,
	output logic                    spi_cs_n,
	output logic                    spi_sck,
	output logic                    spi_sdo
);

	localparam int DIV_W = $clog2(`SPI_CLK_DIV + 1);
	localparam int BIT_W = $clog2(`SPI_FRAME_W);

	spi_state_e              state;
	logic [DIV_W-1:0]        div_cnt;  // Cycles inside the current sck half
	logic [BIT_W-1:0]        bit_cnt;  // Bits already shifted out
	logic [`SPI_FRAME_W-1:0] shreg;
	logic                    half_end;

	assign spi_ready = (state == SPI_IDLE);
	assign half_end  = (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
	assign spi_sdo   = shreg[`SPI_FRAME_W-1] & ~spi_cs_n; // Low outside a transfer

	//////////////////////////////////////////////////
	// Shifter control
	//////////////////////////////////////////////////
	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			state    <= SPI_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			spi_cs_n <= 1'b1;
			spi_sck  <= 1'b0; // Mode 0, idle low
		end else begin
			case (state)
				SPI_IDLE: if (spi_start) begin
					state    <= SPI_SHIFT;
					spi_cs_n <= 1'b0;
					div_cnt  <= '0;
					bit_cnt  <= '0;
				end
				SPI_SHIFT: begin
					div_cnt <= half_end ? '0 : div_cnt + 1'b1;
					if (half_end) begin
						spi_sck <= ~spi_sck;
						// Falling edge, next bit or finish
						if (spi_sck) begin
							if (bit_cnt == BIT_W'(`SPI_FRAME_W - 1))
								state <= SPI_END;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				SPI_END: begin
					spi_cs_n <= 1'b1;
					state    <= SPI_IDLE;
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	// Data shifts on the falling sck edge, ADC samples on the rising one
	always_ff @(posedge hz_clk) begin
		if (state == SPI_IDLE && spi_start)
			shreg <= spi_frame;
		else if (state == SPI_SHIFT && half_end && spi_sck)
			shreg <= {shreg[`SPI_FRAME_W-2:0], 1'b0};
	end

endmodule

/* src/adc_config_sequencer.sv */
`include "adc_rx_defines.svh"

module adc_config_sequencer import adc_rx_pkg::*; (
	input  logic                    hz_clk,
	input  logic                    rst_in,
	input  logic                    cmd_trig,
	input  logic [15:0]             cmd_addr,
	input  logic [15:0]             cmd_data,
	input  logic                    spi_ready,
	output logic                    spi_start,
	output logic [`SPI_FRAME_W-1:0] spi_frame,
	output logic                    cfg_done
);

	localparam int WAIT_W = $clog2(`CFG_POWERUP_WAIT + 1);

	cfg_state_e              state;
	logic [WAIT_W-1:0]       wait_cnt;   // Power-up countdown
	logic [1:0]              script_idx; // Entry of the power-up script
	logic                    ready_q;
	logic                    ready_rise; // SPI transfer finished
	logic [`SPI_FRAME_W-1:0] set_frame;  // User write, latched on the command

	// Power-up register writes, {write, address, data}
	function automatic logic [`SPI_FRAME_W-1:0] script_frame(input logic [1:0] idx);
		case (idx)
			2'd0:    script_frame = {1'b0, 7'h00, 8'h80}; // Software reset
			2'd1:    script_frame = {1'b0, 7'h01, 8'h20}; // Two's complement output
			default: script_frame = {1'b0, 7'h02, 8'h00}; // Two lanes per channel
		endcase
	endfunction

	assign ready_rise = spi_ready && !ready_q;

	//////////////////////////////////////////////////
	// Control state machine
	//////////////////////////////////////////////////
	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			state      <= CFG_WAIT_POWERUP;
			wait_cnt   <= WAIT_W'(`CFG_POWERUP_WAIT - 1);
			script_idx <= '0;
			ready_q    <= 1'b1;
			spi_start  <= 1'b0;
			cfg_done   <= 1'b0;
		end else begin
			ready_q   <= spi_ready;
			spi_start <= 1'b0; // Pulse only
			case (state)
				CFG_WAIT_POWERUP: begin
					if (wait_cnt == '0)
						state <= CFG_LOAD;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				CFG_LOAD: state <= CFG_SEND;
				CFG_SEND: if (spi_ready) begin
					spi_start <= 1'b1;
					state     <= CFG_WAIT_DONE;
				end
				CFG_WAIT_DONE: if (ready_rise) begin
					if (script_idx == 2'd2) begin
						cfg_done <= 1'b1; // Stays high from here on
						state    <= CFG_IDLE;
					end else begin
						script_idx <= script_idx + 1'b1;
						state      <= CFG_LOAD;
					end
				end
				// Other prefixes are dropped
				CFG_IDLE: if (cmd_trig && cmd_addr[15:8] == `CFG_SET_PREFIX) state <= CFG_SET_LOAD;
				CFG_SET_LOAD: state <= CFG_SET_SEND;
				CFG_SET_SEND: if (spi_ready) begin
					spi_start <= 1'b1;
					state     <= CFG_SET_WAIT;
				end
				CFG_SET_WAIT: if (ready_rise) state <= CFG_IDLE;
				default: state <= CFG_IDLE;
			endcase
		end
	end

	// Frame registers, loaded in the load states only
	always_ff @(posedge hz_clk) begin
		if (state == CFG_IDLE && cmd_trig)
			set_frame <= {1'b0, cmd_addr[6:0], cmd_data[7:0]};
		if (state == CFG_LOAD)
			spi_frame <= script_frame(script_idx);
		else if (state == CFG_SET_LOAD)
			spi_frame <= set_frame;
	end

endmodule

/* src/sample_assembler.sv */
`include "adc_rx_defines.svh"

module sample_assembler import adc_rx_pkg::*; (
	input  logic            hz_clk,
	input  logic            rst_in,
	lane_word_if.assembler  words,
	input  logic            frame_locked,
	output sample_t         sample_ch0,
	output sample_t         sample_ch1,
	output logic            sample_valid
);

	localparam logic [`ADC_N_DATA_LANES-1:0] INV_MASK = `ADC_LANE_INVERT;

	lane_words_t fixed;    // Lane words after polarity correction
	logic        capture;

	// Two-lane mode, lane a carries the odd sample bits and lane b the even ones
	function automatic sample_t interleave(input lane_word_t lane_a, input lane_word_t lane_b);
		sample_t s;
		for (int k = 0; k < `ADC_WORD_W; k++) begin
			s[2*k+1] = lane_a[k];
			s[2*k]   = lane_b[k];
		end
		return s;
	endfunction

	//////////////////////////////////////////////////
	// Polarity correction
	//////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < `ADC_N_DATA_LANES; i++) begin
			fixed[i] = words.data_words[i] ^ {`ADC_WORD_W{INV_MASK[i]}}; // Swapped pairs
		end
	end

	assign capture = words.word_valid && frame_locked; // Only aligned words make samples

	// Samples held between strobes
	always_ff @(posedge hz_clk) begin
		if (capture) begin
			sample_ch0 <= interleave(fixed[0], fixed[1]);
			sample_ch1 <= interleave(fixed[2], fixed[3]);
		end
	end

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in)
			sample_valid <= 1'b0;
		else
			sample_valid <= capture; // One cycle after the word strobe
	end

endmodule

/* src/frame_aligner.sv */
`include "adc_rx_defines.svh"

module frame_aligner import adc_rx_pkg::*; (
	input  logic          hz_clk,
	input  logic          rst_in,
	lane_word_if.aligner  words,
	output logic          frame_locked
);

	localparam int GUARD_W = $clog2(`ADC_SLIP_WAIT + 1);

	aligner_state_e     state;
	logic [GUARD_W-1:0] guard_cnt;   // Words seen since the last slip, saturates
	logic               pattern_ok;
	logic               slip_ok;

	assign pattern_ok = (words.frame_word == lane_word_t'(`ADC_FRAME_PATTERN));
	assign slip_ok    = (guard_cnt >= GUARD_W'(`ADC_SLIP_WAIT)); // Previous slip has settled

	assign words.bitslip = (state == ALN_SLIP); // Decoded from state, never on a strobe cycle

	//////////////////////////////////////////////////
	// CHECK/SLIP state machine
	//////////////////////////////////////////////////
	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			state        <= ALN_CHECK;
			guard_cnt    <= GUARD_W'(`ADC_SLIP_WAIT); // First mismatch may slip at once
			frame_locked <= 1'b0;
		end else begin
			case (state)
				ALN_CHECK: if (words.word_valid) begin
					frame_locked <= pattern_ok; // Lock follows each compare
					if (!pattern_ok && slip_ok)
						state <= ALN_SLIP;
					else if (!slip_ok)
						guard_cnt <= guard_cnt + 1'b1;
				end
				ALN_SLIP: begin
					state     <= ALN_CHECK;
					guard_cnt <= '0; // Restart the settle window
				end
				default: state <= ALN_CHECK;
			endcase
		end
	end

endmodule

/* src/lane_deserializer.sv */
`include "adc_rx_defines.svh"

module lane_deserializer import adc_rx_pkg::*; (
	input  logic                         hz_clk,
	input  logic                         rst_in,
	input  logic                         frame_lane,
	input  logic [`ADC_N_DATA_LANES-1:0] data_lanes,
	lane_word_if.deserializer            words
);

	localparam int CNT_W = $clog2(`ADC_WORD_W);

	lane_word_t       frame_sh;  // Frame lane shift register
	lane_words_t      data_sh;   // One shift register per data lane
	logic [CNT_W-1:0] bit_cnt;   // Position inside the current word
	logic             word_end;

	// Last bit of the word arrives this cycle, unless a slip holds the count
	assign word_end = (bit_cnt == CNT_W'(`ADC_WORD_W - 1)) && !words.bitslip;

	//////////////////////////////////////////////////
	// Serial in, MSB first
	//////////////////////////////////////////////////
	always_ff @(posedge hz_clk) begin
		frame_sh <= {frame_sh[`ADC_WORD_W-2:0], frame_lane};
		for (int i = 0; i < `ADC_N_DATA_LANES; i++) begin
			data_sh[i] <= {data_sh[i][`ADC_WORD_W-2:0], data_lanes[i]};
		end
	end

	// Parallel word registers, stable until the next strobe
	always_ff @(posedge hz_clk) begin
		if (word_end) begin
			words.frame_word <= {frame_sh[`ADC_WORD_W-2:0], frame_lane}; // Include current bit
			for (int i = 0; i < `ADC_N_DATA_LANES; i++) begin
				words.data_words[i] <= {data_sh[i][`ADC_WORD_W-2:0], data_lanes[i]};
			end
		end
	end

	//////////////////////////////////////////////////
	// Bit counter and word strobe
	//////////////////////////////////////////////////
	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			bit_cnt          <= '0;
			words.word_valid <= 1'b0;
		end else begin
			words.word_valid <= word_end;
			if (word_end)
				bit_cnt <= '0;
			else if (!words.bitslip)
				bit_cnt <= bit_cnt + 1'b1; // Held one cycle on bitslip, word becomes 9 bits long
		end
	end

endmodule

/* src/lane_word_if.sv */
// Words from the deserializer, shared by aligner and assembler
interface lane_word_if import adc_rx_pkg::*; ();

	lane_word_t  frame_word;  // Frame lane, compared against the pattern
	lane_words_t data_words;  // ch0a, ch0b, ch1a, ch1b
	logic        word_valid;  // One cycle strobe per word
	logic        bitslip;     // One cycle pulse, moves boundary a bit later

	//////////////////////////////////////////////////
	// Producer side
	//////////////////////////////////////////////////
	modport deserializer (
		output frame_word,
		output data_words,
		output word_valid,
		input  bitslip
	);

	// Bitslip state machine, looks only at the frame lane
	modport aligner (
		input  frame_word,
		input  word_valid,
		output bitslip
	);

	//////////////////////////////////////////////////
	// Consumer side
	//////////////////////////////////////////////////
	modport assembler (
		input  data_words,
		input  word_valid
	);

endinterface

/* src/adc_rx_pkg.sv */
`include "adc_rx_defines.svh"

package adc_rx_pkg;

	// One deserialized lane word
	typedef logic [`ADC_WORD_W-1:0] lane_word_t;
	typedef lane_word_t [`ADC_N_DATA_LANES-1:0] lane_words_t; // All data lanes, index 0 is ch0a

	typedef logic signed [`ADC_SAMPLE_W-1:0] sample_t; // Two's complement sample

	// Bitslip control
	typedef enum logic {
		ALN_CHECK, // Compare frame word on each strobe
		ALN_SLIP   // One cycle bitslip pulse
	} aligner_state_e;

	typedef enum logic [2:0] {
		CFG_WAIT_POWERUP, // Count down after reset
		CFG_LOAD,         // Power-up script entry into SPI frame
		CFG_SEND,
		CFG_WAIT_DONE,
		CFG_IDLE,         // Accept user commands
		CFG_SET_LOAD,
		CFG_SET_SEND,
		CFG_SET_WAIT
	} cfg_state_e;

	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_SHIFT, // 16 bit periods
		SPI_END    // Last cycle with cs_n low
	} spi_state_e;

endpackage

/* include/adc_rx_defines.svh */
`ifndef ADC_RX_DEFINES_SVH
`define ADC_RX_DEFINES_SVH

//////////////////////////////////////////////////
// Lane and sample geometry
//////////////////////////////////////////////////

`define ADC_WORD_W        8        // Bits per lane word
`define ADC_SAMPLE_W      16       // Two lanes of 8 make one sample
`define ADC_N_DATA_LANES  4        // ch0a, ch0b, ch1a, ch1b

// Training word on the frame lane
`define ADC_FRAME_PATTERN 8'h0F
`define ADC_SLIP_WAIT     3        // Words to let pass after a slip

// Board swaps the pair of ch0b, so that lane arrives inverted
`define ADC_LANE_INVERT   4'b0010

//////////////////////////////////////////////////
// SPI and configuration
//////////////////////////////////////////////////

`define SPI_CLK_DIV       4        // hz_clk cycles per sck half period
`define SPI_FRAME_W       16       // R/W bit, 7 bit address, 8 bit data

// Settle time for the ADC after reset
`define CFG_POWERUP_WAIT  255
`define CFG_SET_PREFIX    8'h31    // Upper address byte of a write command

`endif
